// File: hw/wb_pkg.sv
/*
 * Shared definitions for the writeback stage.
 * Holds widths, the CPSR layout, processor mode codes, exception
 * vectors and the physical register map. RTL files refer to these
 * items by scoped names.
 */
package wb_pkg;

        // ------------------------------
        // Widths
        // ------------------------------

        localparam int unsigned XLEN      = 32;
        localparam int unsigned PHY_REGS  = 40;
        localparam int unsigned REG_IDX_W = 6;

        typedef logic [REG_IDX_W-1:0] reg_idx_t;

        // CPSR seen as one word or as its fields.
        typedef union packed {
                logic [XLEN-1:0] raw;
                struct packed {
                        logic [3:0]  flags;
                        logic [19:0] reserved;
                        logic        irq_mask;
                        logic        fiq_mask;
                        logic        t_unused;
                        logic [4:0]  mode;
                } fields;
        } cpsr_t;

        // ------------------------------
        // Processor modes
        // ------------------------------

        localparam logic [4:0] MODE_USR = 5'b10000;
        localparam logic [4:0] MODE_FIQ = 5'b10001;
        localparam logic [4:0] MODE_IRQ = 5'b10010;
        localparam logic [4:0] MODE_SVC = 5'b10011;
        localparam logic [4:0] MODE_ABT = 5'b10111;
        localparam logic [4:0] MODE_UND = 5'b11011;

        // SVC mode, IRQ and FIQ masked.
        localparam logic [XLEN-1:0] CPSR_INIT = 32'h0000_00D3;

        // ------------------------------
        // Vectors
        // ------------------------------

        localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;
        localparam logic [XLEN-1:0] UND_VECTOR   = 32'h0000_0004;
        localparam logic [XLEN-1:0] SWI_VECTOR   = 32'h0000_0008;
        localparam logic [XLEN-1:0] PABT_VECTOR  = 32'h0000_000C;
        localparam logic [XLEN-1:0] DABT_VECTOR  = 32'h0000_0010;
        localparam logic [XLEN-1:0] IRQ_VECTOR   = 32'h0000_0018;
        localparam logic [XLEN-1:0] FIQ_VECTOR   = 32'h0000_001C;

        localparam logic [XLEN-1:0] PC_STEP = 32'd4;

        // ------------------------------
        // Physical register map
        // ------------------------------

        localparam reg_idx_t ARCH_PC      = 6'd15;
        localparam reg_idx_t PHY_RAZ      = 6'd16;

        // Banked link registers.
        localparam reg_idx_t PHY_FIQ_R14  = 6'd17;
        localparam reg_idx_t PHY_IRQ_R14  = 6'd18;
        localparam reg_idx_t PHY_SVC_R14  = 6'd19;
        localparam reg_idx_t PHY_ABT_R14  = 6'd20;
        localparam reg_idx_t PHY_UND_R14  = 6'd21;

        // Saved program status registers.
        localparam reg_idx_t PHY_FIQ_SPSR = 6'd22;
        localparam reg_idx_t PHY_IRQ_SPSR = 6'd23;
        localparam reg_idx_t PHY_SVC_SPSR = 6'd24;
        localparam reg_idx_t PHY_ABT_SPSR = 6'd25;
        localparam reg_idx_t PHY_UND_SPSR = 6'd26;

endpackage

// File: hw/wb_exception_arbiter.sv
/*
 * Exception and retirement arbiter of the writeback stage.
 * Ranks aborts, interrupts, SWI, undefined and normal retirement by
 * fixed priority, then drives two register-file write ports, a fetch
 * redirect and the next CPSR. Owns the CPSR register.
 */
`timescale 1ns/1ps

module wb_exception_arbiter
(
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_valid,
        input  logic                     i_mem_load,
        input  logic                     i_irq,
        input  logic                     i_fiq,
        input  logic                     i_instr_abt,
        input  logic                     i_swi,
        input  logic                     i_und,
        input  logic [1:0]               i_data_abt,
        input  wb_pkg::reg_idx_t         i_wr_index,
        input  wb_pkg::reg_idx_t         i_wr_index_1,
        input  logic [wb_pkg::XLEN-1:0]  i_wr_data,
        input  logic [wb_pkg::XLEN-1:0]  i_wr_data_1,
        input  logic [wb_pkg::XLEN-1:0]  i_pc_plus_8,
        input  logic [wb_pkg::XLEN-1:0]  i_flags,
        input  logic [wb_pkg::XLEN-1:0]  i_pc_from_alu,
        input  logic [wb_pkg::XLEN-1:0]  i_pc_from_decode,
        input  logic                     i_clear_from_alu,
        input  logic                     i_clear_from_decode,

        output logic                     o_wen,
        output wb_pkg::reg_idx_t         o_wr_addr_a,
        output wb_pkg::reg_idx_t         o_wr_addr_b,
        output logic [wb_pkg::XLEN-1:0]  o_wr_data_a,
        output logic [wb_pkg::XLEN-1:0]  o_wr_data_b,
        output logic                     o_redirect,
        output logic [wb_pkg::XLEN-1:0]  o_redirect_pc,
        output logic                     o_clear_from_writeback,
        output wb_pkg::cpsr_t            o_cpsr
);

wb_pkg::cpsr_t                  cpsr_ff, cpsr_nxt;

logic                           exc_take;
logic                           exc_fiq;
logic [4:0]                     exc_mode;
wb_pkg::reg_idx_t               exc_r14, exc_spsr;
logic [wb_pkg::XLEN-1:0]        exc_vector, exc_lr;
logic                           load_pc;

assign o_cpsr  = cpsr_ff;
assign load_pc = i_valid && i_mem_load && (i_wr_index_1 == wb_pkg::ARCH_PC);

// ------------------------------
// Exception select
// ------------------------------

// Highest pending exception below the restart.
always_comb
begin
        exc_take   = 1'b1;
        exc_fiq    = 1'b0;
        exc_mode   = wb_pkg::MODE_UND;
        exc_r14    = wb_pkg::PHY_UND_R14;
        exc_spsr   = wb_pkg::PHY_UND_SPSR;
        exc_vector = wb_pkg::UND_VECTOR;
        exc_lr     = i_wr_data;

        if (i_data_abt[0])
        begin
                // Link holds PC+8 so the handler can retry the access.
                exc_mode   = wb_pkg::MODE_ABT;
                exc_r14    = wb_pkg::PHY_ABT_R14;
                exc_spsr   = wb_pkg::PHY_ABT_SPSR;
                exc_vector = wb_pkg::DABT_VECTOR;
                exc_lr     = i_pc_plus_8;
        end
        else if (i_fiq)
        begin
                exc_fiq    = 1'b1;
                exc_mode   = wb_pkg::MODE_FIQ;
                exc_r14    = wb_pkg::PHY_FIQ_R14;
                exc_spsr   = wb_pkg::PHY_FIQ_SPSR;
                exc_vector = wb_pkg::FIQ_VECTOR;
        end
        else if (i_irq)
        begin
                exc_mode   = wb_pkg::MODE_IRQ;
                exc_r14    = wb_pkg::PHY_IRQ_R14;
                exc_spsr   = wb_pkg::PHY_IRQ_SPSR;
                exc_vector = wb_pkg::IRQ_VECTOR;
        end
        else if (i_instr_abt)
        begin
                exc_mode   = wb_pkg::MODE_ABT;
                exc_r14    = wb_pkg::PHY_ABT_R14;
                exc_spsr   = wb_pkg::PHY_ABT_SPSR;
                exc_vector = wb_pkg::PABT_VECTOR;
        end
        else if (i_swi)
        begin
                exc_mode   = wb_pkg::MODE_SVC;
                exc_r14    = wb_pkg::PHY_SVC_R14;
                exc_spsr   = wb_pkg::PHY_SVC_SPSR;
                exc_vector = wb_pkg::SWI_VECTOR;
        end
        else if (!i_und)
        begin
                exc_take = 1'b0;
        end
end

// ------------------------------
// Writes and redirect
// ------------------------------

always_comb
begin
        o_wen                  = 1'b0;
        o_wr_addr_a            = wb_pkg::PHY_RAZ;
        o_wr_addr_b            = wb_pkg::PHY_RAZ;
        o_wr_data_a            = '0;
        o_wr_data_b            = '0;
        o_redirect             = 1'b0;
        o_redirect_pc          = '0;
        o_clear_from_writeback = 1'b0;
        cpsr_nxt               = cpsr_ff;

        if (i_data_abt[1])
        begin
                // Restart the faulting instruction, no state change.
                o_redirect             = 1'b1;
                o_redirect_pc          = i_pc_plus_8 - 32'd8;
                o_clear_from_writeback = 1'b1;
        end
        else if (exc_take)
        begin
                o_wen                     = 1'b1;
                o_wr_addr_a               = exc_r14;
                o_wr_data_a               = exc_lr;
                o_wr_addr_b               = exc_spsr;
                o_wr_data_b               = cpsr_ff.raw;
                cpsr_nxt.fields.mode      = exc_mode;
                cpsr_nxt.fields.irq_mask  = 1'b1;
                if (exc_fiq)
                begin
                        cpsr_nxt.fields.fiq_mask = 1'b1;
                end
                o_redirect                = 1'b1;
                o_redirect_pc             = exc_vector;
        end
        else
        begin
                if (i_valid)
                begin
                        cpsr_nxt.raw = i_flags;
                        o_wen        = 1'b1;
                        o_wr_addr_a  = i_wr_index;
                        o_wr_data_a  = i_wr_data;
                        o_wr_addr_b  = i_mem_load ? i_wr_index_1 : wb_pkg::PHY_RAZ;
                        o_wr_data_b  = i_wr_data_1;
                end

                // A load into the PC outranks the earlier stages.
                if (load_pc)
                begin
                        o_redirect             = 1'b1;
                        o_redirect_pc          = i_wr_data_1;
                        o_clear_from_writeback = 1'b1;
                end
                else if (i_clear_from_alu)
                begin
                        o_redirect    = 1'b1;
                        o_redirect_pc = i_pc_from_alu;
                end
                else if (i_clear_from_decode)
                begin
                        o_redirect    = 1'b1;
                        o_redirect_pc = i_pc_from_decode;
                end
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cpsr_ff.raw <= wb_pkg::CPSR_INIT;
        end
        else
        begin
                cpsr_ff <= cpsr_nxt;
        end
end

endmodule

// File: hw/wb_register_file.sv
/*
 * Banked physical register file.
 * Two write ports share one enable and land on the clock edge, port B
 * winning on a clash. Two combinational read ports. The RAZ index
 * reads as zero and swallows writes.
 */
`timescale 1ns/1ps

module wb_register_file
(
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_wen,
        input  wb_pkg::reg_idx_t         i_wr_addr_a,
        input  wb_pkg::reg_idx_t         i_wr_addr_b,
        input  wb_pkg::reg_idx_t         i_rd_addr_a,
        input  wb_pkg::reg_idx_t         i_rd_addr_b,
        input  logic [wb_pkg::XLEN-1:0]  i_wr_data_a,
        input  logic [wb_pkg::XLEN-1:0]  i_wr_data_b,

        output logic [wb_pkg::XLEN-1:0]  o_rd_data_a,
        output logic [wb_pkg::XLEN-1:0]  o_rd_data_b
);

logic [wb_pkg::XLEN-1:0] regs [wb_pkg::PHY_REGS];

// Index maps to real storage.
function automatic logic is_real(input wb_pkg::reg_idx_t idx);
        return (idx != wb_pkg::PHY_RAZ) && (idx < wb_pkg::PHY_REGS);
endfunction

// ------------------------------
// Write ports
// ------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int k = 0; k < wb_pkg::PHY_REGS; k++)
                begin
                        regs[k] <= '0;
                end
        end
        else if (i_wen)
        begin
                if (is_real(i_wr_addr_a))
                begin
                        regs[i_wr_addr_a] <= i_wr_data_a;
                end
                // Later assignment, so B takes a shared index.
                if (is_real(i_wr_addr_b))
                begin
                        regs[i_wr_addr_b] <= i_wr_data_b;
                end
        end
end

// ------------------------------
// Read ports
// ------------------------------

assign o_rd_data_a = is_real(i_rd_addr_a) ? regs[i_rd_addr_a] : '0;
assign o_rd_data_b = is_real(i_rd_addr_b) ? regs[i_rd_addr_b] : '0;

endmodule

// File: hw/wb_pc_sequencer.sv
/*
 * Fetch program counter sequencer.
 * Holds the next PC and three valid-tagged delayed copies. A redirect
 * is shelved for one cycle, then reloads the next PC and empties the
 * delay line. The oldest copy drives the bus address and strobe.
 */
`timescale 1ns/1ps

module wb_pc_sequencer
(
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_code_stall,
        input  logic                     i_redirect,
        input  logic [wb_pkg::XLEN-1:0]  i_redirect_pc,

        output logic [wb_pkg::XLEN-1:0]  o_pc_nxt,
        output logic [wb_pkg::XLEN-1:0]  o_pc_check,
        output logic [wb_pkg::XLEN-1:0]  o_pc,
        output logic                     o_wb_stb
);

// Top bit of each PC word is its valid tag.
logic [wb_pkg::XLEN:0]    pc_ff, pc_nxt;
logic [wb_pkg::XLEN:0]    pc_del_ff, pc_del_nxt;
logic [wb_pkg::XLEN:0]    pc_del2_ff, pc_del2_nxt;
logic [wb_pkg::XLEN:0]    pc_del3_ff, pc_del3_nxt;
logic                     shelve_ff, shelve_nxt;
logic [wb_pkg::XLEN-1:0]  pc_shelve_ff, pc_shelve_nxt;

assign o_pc_nxt   = pc_ff[wb_pkg::XLEN-1:0];
assign o_pc_check = pc_del2_ff[wb_pkg::XLEN-1:0];
assign o_pc       = pc_del3_ff[wb_pkg::XLEN-1:0];
assign o_wb_stb   = pc_del3_ff[wb_pkg::XLEN];

// ------------------------------
// Next state
// ------------------------------

always_comb
begin
        shelve_nxt    = shelve_ff;
        pc_shelve_nxt = pc_shelve_ff;
        pc_nxt        = pc_ff;
        pc_del_nxt    = pc_del_ff;
        pc_del2_nxt   = pc_del2_ff;
        pc_del3_nxt   = pc_del3_ff;

        if (i_redirect)
        begin
                // Park the target, the PC holds this cycle.
                shelve_nxt    = 1'b1;
                pc_shelve_nxt = i_redirect_pc;
        end
        else if (i_code_stall)
        begin
                // Everything frozen, shelve stays pending.
        end
        else if (shelve_ff)
        begin
                pc_nxt      = {1'b1, pc_shelve_ff};
                pc_del_nxt  = '0;
                pc_del2_nxt = '0;
                pc_del3_nxt = '0;
                shelve_nxt  = 1'b0;
        end
        else
        begin
                pc_nxt[wb_pkg::XLEN-1:0] = pc_ff[wb_pkg::XLEN-1:0] + wb_pkg::PC_STEP;
                pc_del_nxt               = pc_ff;
                pc_del2_nxt              = pc_del_ff;
                pc_del3_nxt              = pc_del2_ff;
        end

        // Instructions are halfword aligned at least.
        pc_nxt[0] = 1'b0;
end

// ------------------------------
// State
// ------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                shelve_ff  <= 1'b0;
                pc_ff      <= {1'b1, wb_pkg::RESET_VECTOR};
                pc_del_ff  <= '0;
                pc_del2_ff <= '0;
                pc_del3_ff <= '0;
        end
        else
        begin
                shelve_ff  <= shelve_nxt;
                pc_ff      <= pc_nxt;
                pc_del_ff  <= pc_del_nxt;
                pc_del2_ff <= pc_del2_nxt;
                pc_del3_ff <= pc_del3_nxt;
        end
end

// Target word, only meaningful while shelved.
always_ff @(posedge i_clk)
begin
        pc_shelve_ff <= pc_shelve_nxt;
end

endmodule

// File: hw/wb_stage_top.sv
/*
 * Writeback stage top level.
 * The arbiter feeds write commands to the register file and redirects
 * to the PC sequencer. External logic reads the register file through
 * two indices and stalls fetch through i_code_stall.
 */
`timescale 1ns/1ps

module wb_stage_top
(
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_valid,
        input  logic                     i_mem_load,
        input  logic                     i_irq,
        input  logic                     i_fiq,
        input  logic                     i_instr_abt,
        input  logic                     i_swi,
        input  logic                     i_und,
        input  logic [1:0]               i_data_abt,
        input  wb_pkg::reg_idx_t         i_wr_index,
        input  wb_pkg::reg_idx_t         i_wr_index_1,
        input  logic [wb_pkg::XLEN-1:0]  i_wr_data,
        input  logic [wb_pkg::XLEN-1:0]  i_wr_data_1,
        input  logic [wb_pkg::XLEN-1:0]  i_pc_plus_8,
        input  logic [wb_pkg::XLEN-1:0]  i_flags,
        input  logic [wb_pkg::XLEN-1:0]  i_pc_from_alu,
        input  logic [wb_pkg::XLEN-1:0]  i_pc_from_decode,
        input  logic                     i_clear_from_alu,
        input  logic                     i_clear_from_decode,
        input  logic                     i_code_stall,
        input  wb_pkg::reg_idx_t         i_rd_index_0,
        input  wb_pkg::reg_idx_t         i_rd_index_1,

        output logic [wb_pkg::XLEN-1:0]  o_rd_data_0,
        output logic [wb_pkg::XLEN-1:0]  o_rd_data_1,
        output logic                     o_clear_from_writeback,
        output wb_pkg::cpsr_t            o_cpsr,
        output logic [wb_pkg::XLEN-1:0]  o_pc_nxt,
        output logic [wb_pkg::XLEN-1:0]  o_pc_check,
        output logic [wb_pkg::XLEN-1:0]  o_pc,
        output logic                     o_wb_stb
);

logic                     wen;
wb_pkg::reg_idx_t         wr_addr_a, wr_addr_b;
logic [wb_pkg::XLEN-1:0]  wr_data_a, wr_data_b;
logic                     redirect;
logic [wb_pkg::XLEN-1:0]  redirect_pc;

wb_exception_arbiter u_arbiter
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_valid                (i_valid),
        .i_mem_load             (i_mem_load),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_instr_abt            (i_instr_abt),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .i_data_abt             (i_data_abt),
        .i_wr_index             (i_wr_index),
        .i_wr_index_1           (i_wr_index_1),
        .i_wr_data              (i_wr_data),
        .i_wr_data_1            (i_wr_data_1),
        .i_pc_plus_8            (i_pc_plus_8),
        .i_flags                (i_flags),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .o_wen                  (wen),
        .o_wr_addr_a            (wr_addr_a),
        .o_wr_addr_b            (wr_addr_b),
        .o_wr_data_a            (wr_data_a),
        .o_wr_data_b            (wr_data_b),
        .o_redirect             (redirect),
        .o_redirect_pc          (redirect_pc),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_cpsr                 (o_cpsr)
);

wb_register_file u_regfile
(
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wen       (wen),
        .i_wr_addr_a (wr_addr_a),
        .i_wr_addr_b (wr_addr_b),
        .i_rd_addr_a (i_rd_index_0),
        .i_rd_addr_b (i_rd_index_1),
        .i_wr_data_a (wr_data_a),
        .i_wr_data_b (wr_data_b),
        .o_rd_data_a (o_rd_data_0),
        .o_rd_data_b (o_rd_data_1)
);

wb_pc_sequencer u_pc_seq
(
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_code_stall  (i_code_stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_pc_nxt      (o_pc_nxt),
        .o_pc_check    (o_pc_check),
        .o_pc          (o_pc),
        .o_wb_stb      (o_wb_stb)
);

endmodule

// File: dv/wb_stage_tb.sv
/*
 * Trace-driven testbench for the writeback stage.
 * Each trace line is one clock cycle. Inputs are driven on the rising
 * edge and the masked outputs are compared at the falling edge.
 */
`timescale 1ns/1ps

module wb_stage_tb;

localparam int CLK_HALF = 50;
localparam int NCOL     = 17;
localparam int MAX_ROWS = 64;

// Trace columns.
localparam int C_TEST   = 0;
localparam int C_CTL    = 1;
localparam int C_WI     = 2;
localparam int C_WI1    = 3;
localparam int C_WD     = 4;
localparam int C_WD1    = 5;
localparam int C_FLAGS  = 6;
localparam int C_RD0    = 7;
localparam int C_RD1    = 8;
localparam int C_MASK   = 9;
localparam int C_PC_NXT = 10;
localparam int C_STB    = 11;
localparam int C_PC     = 12;
localparam int C_CPSR   = 13;
localparam int C_RDD0   = 14;
localparam int C_RDD1   = 15;
localparam int C_CLR    = 16;

logic                     i_clk, i_reset;
logic                     i_valid, i_mem_load, i_irq, i_fiq;
logic                     i_instr_abt, i_swi, i_und;
logic [1:0]               i_data_abt;
wb_pkg::reg_idx_t         i_wr_index, i_wr_index_1;
logic [wb_pkg::XLEN-1:0]  i_wr_data, i_wr_data_1, i_pc_plus_8, i_flags;
logic [wb_pkg::XLEN-1:0]  i_pc_from_alu, i_pc_from_decode;
logic                     i_clear_from_alu, i_clear_from_decode, i_code_stall;
wb_pkg::reg_idx_t         i_rd_index_0, i_rd_index_1;
logic [wb_pkg::XLEN-1:0]  o_rd_data_0, o_rd_data_1;
logic                     o_clear_from_writeback;
logic [wb_pkg::XLEN-1:0]  o_cpsr;
logic [wb_pkg::XLEN-1:0]  o_pc_nxt, o_pc_check, o_pc;
logic                     o_wb_stb;

logic [31:0]  trace_mem [MAX_ROWS][NCOL];
int           row_count;
logic         load_ok;
int           cycle_limit;
int           cycle_count;
int           current_test;
int           checks_passed, checks_failed;
int           tests_passed, tests_failed;
int           test_checks, test_errors;

wb_stage_top DUT
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_valid                (i_valid),
        .i_mem_load             (i_mem_load),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_instr_abt            (i_instr_abt),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .i_data_abt             (i_data_abt),
        .i_wr_index             (i_wr_index),
        .i_wr_index_1           (i_wr_index_1),
        .i_wr_data              (i_wr_data),
        .i_wr_data_1            (i_wr_data_1),
        .i_pc_plus_8            (i_pc_plus_8),
        .i_flags                (i_flags),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_code_stall           (i_code_stall),
        .i_rd_index_0           (i_rd_index_0),
        .i_rd_index_1           (i_rd_index_1),
        .o_rd_data_0            (o_rd_data_0),
        .o_rd_data_1            (o_rd_data_1),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_cpsr                 (o_cpsr),
        .o_pc_nxt               (o_pc_nxt),
        .o_pc_check             (o_pc_check),
        .o_pc                   (o_pc),
        .o_wb_stb               (o_wb_stb)
);

initial
begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
end

// ------------------------------
// Trace loading
// ------------------------------

task automatic load_trace();
        int               fd;
        int               n;
        int               got;
        logic [31:0]      f [NCOL];
        logic [8*256-1:0] line_buf;

        row_count = 0;
        fd = $fopen("dv/wb_stage_trace.txt", "r");
        if (fd == 0)
        begin
                $display("Could not open the trace file dv/wb_stage_trace.txt");
                load_ok = 1'b0;
        end
        else
        begin
                load_ok  = 1'b1;
                line_buf = '0;
                n = $fgets(line_buf, fd);
                while (n != 0)
                begin
                        got = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                        // Comment and blank lines give no fields.
                        if (got == NCOL && row_count < MAX_ROWS)
                        begin
                                for (int c = 0; c < NCOL; c++)
                                begin
                                        trace_mem[row_count][c] = f[c];
                                end
                                row_count++;
                        end
                        else if (got > 0)
                        begin
                                $display("Trace line after vector %0d is malformed or too many",
                                         row_count);
                                load_ok = 1'b0;
                        end
                        line_buf = '0;
                        n = $fgets(line_buf, fd);
                end
                $fclose(fd);
                if (row_count == 0)
                begin
                        $display("The trace file holds no vectors");
                        load_ok = 1'b0;
                end
        end
endtask

// ------------------------------
// Stimulus and checks
// ------------------------------

task automatic init_inputs();
        i_reset             = 1'b1;
        i_valid             = 1'b0;
        i_mem_load          = 1'b0;
        i_irq               = 1'b0;
        i_fiq               = 1'b0;
        i_instr_abt         = 1'b0;
        i_swi               = 1'b0;
        i_und               = 1'b0;
        i_data_abt          = 2'b00;
        i_wr_index          = '0;
        i_wr_index_1        = '0;
        i_wr_data           = '0;
        i_wr_data_1         = '0;
        i_pc_plus_8         = '0;
        i_flags             = '0;
        i_pc_from_alu       = '0;
        i_pc_from_decode    = '0;
        i_clear_from_alu    = 1'b0;
        i_clear_from_decode = 1'b0;
        i_code_stall        = 1'b0;
        i_rd_index_0        = '0;
        i_rd_index_1        = '0;
endtask

// Reset is seen high on the first two rising edges.
task automatic apply_reset();
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
endtask

task automatic drive_row(input int r);
        logic [31:0] ctl;

        ctl = trace_mem[r][C_CTL];
        i_valid      <= ctl[0];
        i_mem_load   <= ctl[1];
        i_irq        <= ctl[2];
        i_fiq        <= ctl[3];
        i_instr_abt  <= ctl[4];
        i_swi        <= ctl[5];
        i_und        <= ctl[6];
        i_code_stall <= ctl[7];
        i_wr_index   <= trace_mem[r][C_WI][5:0];
        i_wr_index_1 <= trace_mem[r][C_WI1][5:0];
        i_wr_data    <= trace_mem[r][C_WD];
        i_wr_data_1  <= trace_mem[r][C_WD1];
        i_flags      <= trace_mem[r][C_FLAGS];
        i_rd_index_0 <= trace_mem[r][C_RD0][5:0];
        i_rd_index_1 <= trace_mem[r][C_RD1][5:0];
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        test_checks++;
        assert (got === exp)
        begin
                checks_passed++;
        end
        else
        begin
                $display("[FAIL] %0t ns: test %0d, %s is %h, expected %h",
                         $time, current_test, name, got, exp);
                checks_failed++;
                test_errors++;
        end
endtask

task automatic compare_row(input int r);
        logic [31:0] mask;

        mask = trace_mem[r][C_MASK];
        if (mask[0]) check_value("o_pc_nxt", o_pc_nxt, trace_mem[r][C_PC_NXT]);
        if (mask[1]) check_value("o_wb_stb", {31'b0, o_wb_stb}, trace_mem[r][C_STB]);
        if (mask[2]) check_value("o_pc", o_pc, trace_mem[r][C_PC]);
        // While the strobe is up, the copy before o_pc is one fetch step ahead.
        if (mask[1] && mask[2] && trace_mem[r][C_STB][0])
        begin
                check_value("o_pc_check", o_pc_check, trace_mem[r][C_PC] + wb_pkg::PC_STEP);
        end
        if (mask[3]) check_value("o_cpsr", o_cpsr, trace_mem[r][C_CPSR]);
        if (mask[4]) check_value("o_rd_data_0", o_rd_data_0, trace_mem[r][C_RDD0]);
        if (mask[5]) check_value("o_rd_data_1", o_rd_data_1, trace_mem[r][C_RDD1]);
        if (mask[6])
        begin
                check_value("o_clear_from_writeback", {31'b0, o_clear_from_writeback},
                            trace_mem[r][C_CLR]);
        end
endtask

task automatic report_test(input int id);
        if (test_errors == 0)
        begin
                tests_passed++;
                $display("Test %0d done: %0d checks ok", id, test_checks);
        end
        else
        begin
                tests_failed++;
                $display("Test %0d done: %0d of %0d checks wrong", id, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
endtask

// ------------------------------
// Main sequence and watchdog
// ------------------------------

initial
begin
        init_inputs();
        load_trace();
        if (load_ok)
        begin
                cycle_limit  = row_count + 20;
                current_test = trace_mem[0][C_TEST];
                apply_reset();
                for (int r = 0; r < row_count; r++)
                begin
                        if (trace_mem[r][C_TEST] != current_test)
                        begin
                                report_test(current_test);
                                current_test = trace_mem[r][C_TEST];
                        end
                        drive_row(r);
                        @(negedge i_clk);
                        compare_row(r);
                        @(posedge i_clk);
                end
                report_test(current_test);
        end
        $display("Tests: %0d ok, %0d wrong. Checks: %0d passed, %0d failed.",
                 tests_passed, tests_failed, checks_passed, checks_failed);
        if (load_ok && checks_failed == 0)
        begin
                $display("SIMULATION PASSED");
        end
        else
        begin
                $display("SIMULATION FAILED");
        end
        $finish;
end

initial
begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
        begin
                @(posedge i_clk);
                cycle_count++;
        end
        $display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
end

endmodule

// File: dv/wb_stage_trace.txt
# test ctl wi wi1 wd wd1 flags rd0 rd1 mask pc_nxt stb pc cpsr rd_data0 rd_data1 clear (all hex)
# ctl bits 0-7: valid mem_load irq fiq instr_abt swi und code_stall; mask bits 0-6 pick pc_nxt..clear
1 00 0 0 0        0        0        0  0  7b 0   0 0   d3       0        0        0
2 00 0 0 0        0        0        0  0  03 4   0 0   0        0        0        0
2 80 0 0 0        0        0        0  0  03 8   0 0   0        0        0        0
2 80 0 0 0        0        0        0  0  03 8   0 0   0        0        0        0
2 00 0 0 0        0        0        0  0  03 8   0 0   0        0        0        0
2 00 0 0 0        0        0        0  0  07 c   1 0   0        0        0        0
2 00 0 0 0        0        0        0  0  07 10  1 4   0        0        0        0
2 80 0 0 0        0        0        0  0  07 14  1 8   0        0        0        0
2 00 0 0 0        0        0        0  0  07 14  1 8   0        0        0        0
3 03 3 5 cafe0003 beef0005 60000010 3  5  79 18  0 0   d3       0        0        0
3 00 0 0 0        0        0        3  5  38 0   0 0   60000010 cafe0003 beef0005 0
3 01 4 6 4444     6666     60000010 4  6  48 0   0 0   60000010 0        0        0
3 00 0 0 0        0        0        4  6  38 0   0 0   60000010 4444     0        0
4 04 0 0 124      0        0        12 17 78 0   0 0   60000010 0        0        0
4 00 0 0 0        0        0        12 17 39 28  0 0   60000092 124      60000010 0
4 00 0 0 0        0        0        0  0  0b 18  0 0   60000092 0        0        0
4 00 0 0 0        0        0        0  0  03 1c  0 0   0        0        0        0
5 0c 0 0 200      0        0        11 16 79 20  0 0   60000092 0        0        0
5 00 0 0 0        0        0        11 16 39 20  0 0   600000d1 200      60000092 0
5 00 0 0 0        0        0        12 17 33 1c  0 0   0        124      60000010 0
6 03 2 f 11       301      200000d1 2  f  48 0   0 0   600000d1 0        0        1
6 00 0 0 0        0        0        2  f  79 20  0 0   200000d1 11       301      0
6 00 0 0 0        0        0        0  0  03 300 0 0   0        0        0        0
6 00 0 0 0        0        0        0  0  03 304 0 0   0        0        0        0
6 00 0 0 0        0        0        0  0  03 308 0 0   0        0        0        0
6 00 0 0 0        0        0        0  0  07 30c 1 300 0        0        0        0

// File: arm_writeback.f
hw/wb_pkg.sv
hw/wb_exception_arbiter.sv
hw/wb_register_file.sv
hw/wb_pc_sequencer.sv
hw/wb_stage_top.sv
dv/wb_stage_tb.sv

// File: Bender.yml
package:
  name: arm_writeback

sources:
  - hw/wb_pkg.sv
  - hw/wb_exception_arbiter.sv
  - hw/wb_register_file.sv
  - hw/wb_pc_sequencer.sv
  - hw/wb_stage_top.sv
  - target: simulation
    files:
      - dv/wb_stage_tb.sv
